/* hw/fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

////////////////////
// Fetch stage constants
////////////////////

// PC loaded on reset
`define FETCH_RESET_PC 32'h0000_0000

// Instruction shown in IF/ID after reset or flush
// Encodes addi x0, x0, 0
`define FETCH_NOP 32'h0000_0013

// Log2 of predictor entry count, 16 entries by default
`define PREDICT_INDEX_BITS 4

`endif

/* hw/imemPkg.sv */
package imemPkg;

    ////////////////////
    // Instruction memory bus
    ////////////////////

    // Byte address on the fetch bus
    typedef logic [31:0] addrT;

    // Raw instruction word
    typedef logic [31:0] instrT;

    // Four-phase handshake state
    // idle        req low, waiting for ack low
    // waitAck     req high, address stable
    // waitRelease req low, waiting for memory to drop ack
    typedef enum logic [1:0] {
        idle        = 2'd0,
        waitAck     = 2'd1,
        waitRelease = 2'd2
    } fetchStateT;

endpackage

/* hw/fetchPkg.sv */
package fetchPkg;

    ////////////////////
    // Branch prediction
    ////////////////////

    // 2-bit saturating counter
    // Top bit set means predict taken
    typedef enum logic [1:0] {
        strongNotTaken = 2'b00,
        weakNotTaken   = 2'b01,
        weakTaken      = 2'b10,
        strongTaken    = 2'b11
    } counterT;

    // One predictor table entry
    // Tag holds word address bits above the index, zero extended
    // Sized for the smallest index, so any table depth fits
    typedef struct packed {
        logic              valid;
        logic [29:0]       tag;
        imemPkg::addrT     target;
        counterT           counter;
    } predictEntryT;

endpackage

/* hw/pcUpdate.sv */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module pcUpdate (
    input  logic              Clk,
    input  logic              reset,
    // Hazard unit
    input  logic              flushPipeAndPc,
    input  logic              pcStall,
    input  logic              ifIdFlush,
    input  logic              ifIdStall,
    // Redirect sources
    input  imemPkg::addrT     jmpAddr,
    input  logic              vicCtrl,
    input  imemPkg::addrT     vicAddr,
    // Predictor lookup at current pc
    input  logic              lookupHit,
    input  imemPkg::addrT     lookupTarget,
    input  fetchPkg::counterT lookupCounter,
    // Instruction memory
    input  logic              imemAck,
    input  imemPkg::instrT    imemData,
    output imemPkg::addrT     pc,
    output logic              imemReq,
    output imemPkg::addrT     imemAddr,
    output logic              iMiss,
    // IF/ID register
    output imemPkg::instrT    ir,
    output logic              irValid,
    output imemPkg::addrT     instrAddr,
    output imemPkg::addrT     predict,
    output fetchPkg::counterT cb,
    output logic              pcSource,
    output logic              pcMatch
);

    imemPkg::fetchStateT state;
    logic                discard;
    logic                redirect;
    logic                completeNow;
    logic                predictTaken;
    imemPkg::addrT       seqPc;
    imemPkg::addrT       pcNext;

    ////////////////////
    // Handshake
    ////////////////////

    // Either redirect kills the fetch in flight
    assign redirect = flushPipeAndPc || vicCtrl;

    assign imemReq = (state == imemPkg::waitAck);

    // Data accepted into IF/ID this edge
    assign completeNow = imemReq && imemAck && !ifIdStall && !discard;

    // Outstanding and not yet delivered
    assign iMiss = imemReq && !completeNow;

    always_ff @(posedge Clk) begin
        if (reset) begin
            state   <= imemPkg::idle;
            discard <= 1'b0;
        end else begin
            case (state)
                imemPkg::idle: begin
                    // Old ack gone and pc settled
                    if (!imemAck && !redirect) begin
                        state   <= imemPkg::waitAck;
                        discard <= 1'b0;
                    end
                end
                imemPkg::waitAck: begin
                    // Discarded data ignores back-pressure
                    if (imemAck && (discard || !ifIdStall)) begin
                        state <= imemPkg::waitRelease;
                    end
                    if (redirect && !completeNow) begin
                        discard <= 1'b1;
                    end
                end
                imemPkg::waitRelease: begin
                    if (!imemAck) begin
                        state <= imemPkg::idle;
                    end
                end
                default: begin
                    state <= imemPkg::idle;
                end
            endcase
        end
    end

    // Address frozen for the whole request
    always_ff @(posedge Clk) begin
        if (state == imemPkg::idle && !imemAck && !redirect) begin
            imemAddr <= pc;
        end
    end

    ////////////////////
    // Next PC
    ////////////////////

    assign predictTaken = lookupHit && lookupCounter[1];
    assign seqPc        = pc + 32'd4;

    // Flush, interrupt, stall, prediction, sequential
    always_comb begin
        if (flushPipeAndPc) begin
            pcNext = jmpAddr;
        end else if (vicCtrl) begin
            pcNext = vicAddr;
        end else if (pcStall) begin
            pcNext = pc;
        end else if (completeNow) begin
            pcNext = predictTaken ? lookupTarget : seqPc;
        end else begin
            pcNext = pc;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            pc <= `FETCH_RESET_PC;
        end else begin
            pc <= pcNext;
        end
    end

    ////////////////////
    // IF/ID register
    ////////////////////

    // Flush beats stall; stall already blocks completeNow
    always_ff @(posedge Clk) begin
        if (reset || flushPipeAndPc || ifIdFlush) begin
            ir       <= `FETCH_NOP;
            irValid  <= 1'b0;
            pcSource <= 1'b0;
            pcMatch  <= 1'b0;
        end else if (completeNow) begin
            ir       <= imemData;
            irValid  <= 1'b1;
            pcSource <= predictTaken;
            pcMatch  <= lookupHit;
        end
    end

    // Lookup payload travels with the instruction
    always_ff @(posedge Clk) begin
        if (completeNow) begin
            instrAddr <= imemAddr;
            predict   <= lookupTarget;
            cb        <= lookupCounter;
        end
    end

endmodule

/* hw/predictCache.sv */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module predictCache #(
    parameter int indexBits = `PREDICT_INDEX_BITS
) (
    input  logic              Clk,
    input  logic              reset,
    // Lookup port
    input  imemPkg::addrT     rAddr,
    output logic              hit,
    output imemPkg::addrT     target,
    output fetchPkg::counterT counter,
    // Update port from execute
    input  logic              we,
    input  imemPkg::addrT     wAddr,
    input  imemPkg::addrT     wTarget,
    input  fetchPkg::counterT wCounter
);

    localparam int entries = 1 << indexBits;

    fetchPkg::predictEntryT entryTable [entries];

    logic [indexBits-1:0] rIndex;
    logic [indexBits-1:0] wIndex;
    logic [29:0]          rTag;
    logic [29:0]          wTag;
    fetchPkg::predictEntryT rEntry;

    ////////////////////
    // Address split
    ////////////////////

    // Byte offset dropped, index right above it
    assign rIndex = rAddr[indexBits+1:2];
    assign wIndex = wAddr[indexBits+1:2];

    // Rest of the word address is the tag
    assign rTag = rAddr[31:2] >> indexBits;
    assign wTag = wAddr[31:2] >> indexBits;

    ////////////////////
    // Table update
    ////////////////////

    always_ff @(posedge Clk) begin
        if (reset) begin
            // Only valid bits cleared
            for (int i = 0; i < entries; i++) begin
                entryTable[i].valid <= 1'b0;
            end
        end else if (we) begin
            entryTable[wIndex] <= '{
                valid:   1'b1,
                tag:     wTag,
                target:  wTarget,
                counter: wCounter
            };
        end
    end

    ////////////////////
    // Lookup
    ////////////////////

    // Reads old contents during a same-edge write
    assign rEntry = entryTable[rIndex];

    assign hit = rEntry.valid && (rEntry.tag == rTag);

    // Miss reports no target and weakest counter
    assign target  = hit ? rEntry.target : '0;
    assign counter = hit ? rEntry.counter : fetchPkg::strongNotTaken;

endmodule

/* hw/fetchLogic.sv */
`timescale 1ns/1ps

module fetchLogic (
    input  logic              Clk,
    input  logic              reset,
    // Hazard unit
    input  logic              flushPipeAndPc,
    input  logic              pcStall,
    input  logic              ifIdFlush,
    input  logic              ifIdStall,
    output logic              iMiss,
    // Execute stage
    input  logic              writeEnable,
    input  fetchPkg::counterT cbNew,
    input  imemPkg::addrT     jmpAddr,
    input  imemPkg::addrT     chJmpAddr,
    input  imemPkg::addrT     jmpInstrAddr,
    // Interrupt controller
    input  logic              vicCtrl,
    input  imemPkg::addrT     vicAddr,
    // To decode
    output imemPkg::instrT    ir,
    output logic              irValid,
    output imemPkg::addrT     pc,
    output imemPkg::addrT     instrAddr,
    output imemPkg::addrT     predict,
    output fetchPkg::counterT cb,
    output logic              pcSource,
    output logic              pcMatch,
    // Instruction memory
    output logic              imemReq,
    output imemPkg::addrT     imemAddr,
    input  logic              imemAck,
    input  imemPkg::instrT    imemData
);

    // Lookup result at current pc
    logic              lookupHit;
    imemPkg::addrT     lookupTarget;
    fetchPkg::counterT lookupCounter;

    ////////////////////
    // PC and IF/ID
    ////////////////////

    pcUpdate i_pcUpdate (
        .Clk            (Clk),
        .reset          (reset),
        .flushPipeAndPc (flushPipeAndPc),
        .pcStall        (pcStall),
        .ifIdFlush      (ifIdFlush),
        .ifIdStall      (ifIdStall),
        .jmpAddr        (jmpAddr),
        .vicCtrl        (vicCtrl),
        .vicAddr        (vicAddr),
        .lookupHit      (lookupHit),
        .lookupTarget   (lookupTarget),
        .lookupCounter  (lookupCounter),
        .imemAck        (imemAck),
        .imemData       (imemData),
        .pc             (pc),
        .imemReq        (imemReq),
        .imemAddr       (imemAddr),
        .iMiss          (iMiss),
        .ir             (ir),
        .irValid        (irValid),
        .instrAddr      (instrAddr),
        .predict        (predict),
        .cb             (cb),
        .pcSource       (pcSource),
        .pcMatch        (pcMatch)
    );

    ////////////////////
    // Branch target cache
    ////////////////////

    // Read at fetch pc, written by resolved branches
    predictCache i_predictCache (
        .Clk      (Clk),
        .reset    (reset),
        .rAddr    (pc),
        .hit      (lookupHit),
        .target   (lookupTarget),
        .counter  (lookupCounter),
        .we       (writeEnable),
        .wAddr    (jmpInstrAddr),
        .wTarget  (chJmpAddr),
        .wCounter (cbNew)
    );

endmodule

/* tb/fetchLogic_props.sv */
`timescale 1ns/1ps

module fetchLogic_props (
    input logic          Clk,
    input logic          reset,
    input logic          imemReq,
    input logic          imemAck,
    input imemPkg::addrT imemAddr,
    input logic          irValid
);

    ////////////////////
    // Memory handshake
    ////////////////////

    // Address frozen until the request drops
    addrStable: assert property (@(posedge Clk) disable iff (reset)
        imemReq |=> !imemReq || $stable(imemAddr))
        else $error("imemAddr moved while imemReq was high");

    // No new request while the previous ack is still up
    noReqUnderAck: assert property (@(posedge Clk) disable iff (reset)
        imemAck && !imemReq |=> !imemReq)
        else $error("imemReq rose while imemAck was high");

    ////////////////////
    // Reset state
    ////////////////////

    resetQuiet: assert property (@(posedge Clk)
        reset |=> !imemReq && !irValid)
        else $error("imemReq or irValid high right after reset");

endmodule

bind pcUpdate fetchLogic_props i_props (
    .Clk      (Clk),
    .reset    (reset),
    .imemReq  (imemReq),
    .imemAck  (imemAck),
    .imemAddr (imemAddr),
    .irValid  (irValid)
);

/* tb/fetchLogicTb.sv */
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetchLogicTb;

    localparam int tableSize  = 1 << `PREDICT_INDEX_BITS;
    localparam int doneTarget = 2000;
    localparam int idleLimit  = 300;

    logic Clk = 1'b0;
    logic reset;
    logic flushPipeAndPc;
    logic pcStall;
    logic ifIdFlush;
    logic ifIdStall;
    logic writeEnable;
    logic vicCtrl;
    logic imemAck;
    fetchPkg::counterT cbNew;
    imemPkg::addrT     jmpAddr;
    imemPkg::addrT     chJmpAddr;
    imemPkg::addrT     jmpInstrAddr;
    imemPkg::addrT     vicAddr;
    imemPkg::instrT    imemData;

    logic              iMiss;
    imemPkg::instrT    ir;
    logic              irValid;
    imemPkg::addrT     pc;
    imemPkg::addrT     instrAddr;
    imemPkg::addrT     predict;
    fetchPkg::counterT cb;
    logic              pcSource;
    logic              pcMatch;
    logic              imemReq;
    imemPkg::addrT     imemAddr;

    logic [31:0] rngState = 32'h93ef97c8;

    // Reference model state
    fetchPkg::predictEntryT modelTable [tableSize];
    imemPkg::addrT     modelPc;
    logic              discarded;
    imemPkg::instrT    expIr;
    logic              expIrValid;
    logic              expPcSource;
    logic              expPcMatch;
    imemPkg::addrT     expInstrAddr;
    imemPkg::addrT     expPredict;
    fetchPkg::counterT expCb;
    logic              payloadKnown;
    logic              lastHit;
    logic              expectReqHeld;
    logic              wasReset;
    logic              timedOut;
    int                completions;
    int                idleCycles;
    int                resetLeft;
    int                nextResetAt;

    // Memory responder
    logic ackPending;
    int   ackDelay;

    always #2 Clk = ~Clk;

    fetchLogic i_fetchLogic (
        .Clk            (Clk),
        .reset          (reset),
        .flushPipeAndPc (flushPipeAndPc),
        .pcStall        (pcStall),
        .ifIdFlush      (ifIdFlush),
        .ifIdStall      (ifIdStall),
        .iMiss          (iMiss),
        .writeEnable    (writeEnable),
        .cbNew          (cbNew),
        .jmpAddr        (jmpAddr),
        .chJmpAddr      (chJmpAddr),
        .jmpInstrAddr   (jmpInstrAddr),
        .vicCtrl        (vicCtrl),
        .vicAddr        (vicAddr),
        .ir             (ir),
        .irValid        (irValid),
        .pc             (pc),
        .instrAddr      (instrAddr),
        .predict        (predict),
        .cb             (cb),
        .pcSource       (pcSource),
        .pcMatch        (pcMatch),
        .imemReq        (imemReq),
        .imemAddr       (imemAddr),
        .imemAck        (imemAck),
        .imemData       (imemData)
    );

    ////////////////////
    // Helpers
    ////////////////////

    // Xorshift32
    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    // Word aligned in a 1 KB window so branches land on fetched code
    function automatic imemPkg::addrT randAddr();
        logic [31:0] r;
        r = nextRand();
        return {22'd0, r[9:2], 2'b00};
    endfunction

    // Memory contents depend on every address bit
    function automatic imemPkg::instrT wordHash(input imemPkg::addrT a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic int tableIndex(input imemPkg::addrT a);
        return int'(a[`PREDICT_INDEX_BITS+1:2]);
    endfunction

    function automatic logic [29:0] tableTag(input imemPkg::addrT a);
        logic [29:0] t;
        t = a[31:2] >> `PREDICT_INDEX_BITS;
        return t;
    endfunction

    task automatic failNow();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic checkAddr(input string name, input imemPkg::addrT got,
                             input imemPkg::addrT exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            failNow();
        end
    endtask

    task automatic checkInstr(input string name, input imemPkg::instrT got,
                              input imemPkg::instrT exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            failNow();
        end
    endtask

    task automatic checkCounter(input string name, input fetchPkg::counterT got,
                                input fetchPkg::counterT exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            failNow();
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
            failNow();
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    // Runs at the falling edge on settled inputs
    task automatic stepModel();
        fetchPkg::predictEntryT entry;
        logic hit;
        logic done;
        entry = modelTable[tableIndex(modelPc)];
        hit = entry.valid && (entry.tag == tableTag(modelPc));
        wasReset = reset;
        expectReqHeld = 1'b0;
        idleCycles++;
        if (reset) begin
            modelPc = `FETCH_RESET_PC;
            for (int i = 0; i < tableSize; i++) begin
                modelTable[i].valid = 1'b0;
            end
            expIr = `FETCH_NOP;
            expIrValid = 1'b0;
            expPcSource = 1'b0;
            expPcMatch = 1'b0;
            discarded = 1'b0;
            // Payload unknown until the next completion
            payloadKnown = 1'b0;
            lastHit = 1'b0;
        end else begin
            done = imemReq && imemAck && !ifIdStall && !discarded;
            checkBit("iMiss", iMiss, imemReq && !done);
            checkBit("lookupHit", i_fetchLogic.lookupHit, hit);
            if (hit) begin
                checkAddr("lookupTarget", i_fetchLogic.lookupTarget, entry.target);
                checkCounter("lookupCounter", i_fetchLogic.lookupCounter, entry.counter);
            end
            // Live request carries the model's fetch address
            if (imemReq && !discarded) begin
                checkAddr("imemAddr", imemAddr, modelPc);
            end
            // Back-pressure keeps the request up
            expectReqHeld = imemReq && imemAck && ifIdStall && !discarded;

            if (flushPipeAndPc || ifIdFlush) begin
                expIr = `FETCH_NOP;
                expIrValid = 1'b0;
                expPcSource = 1'b0;
                expPcMatch = 1'b0;
            end else if (done) begin
                expIr = wordHash(modelPc);
                expIrValid = 1'b1;
                expPcSource = hit && entry.counter[1];
                expPcMatch = hit;
            end
            if (done) begin
                expInstrAddr = modelPc;
                expPredict = entry.target;
                expCb = entry.counter;
                lastHit = hit;
                payloadKnown = 1'b1;
                completions++;
                idleCycles = 0;
            end

            // Redirect overtakes the fetch in flight
            if (imemReq && (flushPipeAndPc || vicCtrl) && !done) begin
                discarded = 1'b1;
            end else if (!imemReq) begin
                discarded = 1'b0;
            end

            if (flushPipeAndPc) begin
                modelPc = jmpAddr;
            end else if (vicCtrl) begin
                modelPc = vicAddr;
            end else if (pcStall) begin
                modelPc = modelPc;
            end else if (done) begin
                modelPc = (hit && entry.counter[1]) ? entry.target : modelPc + 32'd4;
            end

            // Write lands after the lookup above
            if (writeEnable) begin
                modelTable[tableIndex(jmpInstrAddr)] = '{
                    valid:   1'b1,
                    tag:     tableTag(jmpInstrAddr),
                    target:  chJmpAddr,
                    counter: cbNew
                };
            end
        end
    endtask

    task automatic compareOutputs();
        checkAddr("pc", pc, modelPc);
        checkInstr("ir", ir, expIr);
        checkBit("irValid", irValid, expIrValid);
        checkBit("pcSource", pcSource, expPcSource);
        checkBit("pcMatch", pcMatch, expPcMatch);
        if (payloadKnown) begin
            checkAddr("instrAddr", instrAddr, expInstrAddr);
        end
        if (payloadKnown && lastHit) begin
            checkAddr("predict", predict, expPredict);
            checkCounter("cb", cb, expCb);
        end
        if (wasReset) begin
            checkBit("imemReq", imemReq, 1'b0);
        end
        if (expectReqHeld) begin
            checkBit("imemReq", imemReq, 1'b1);
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic driveHazards();
        logic [31:0] r;
        // Several resets mid-run
        if (completions >= nextResetAt) begin
            resetLeft = 3;
            nextResetAt = nextResetAt + 500;
        end
        reset = (resetLeft > 0);
        if (resetLeft > 0) begin
            resetLeft--;
        end

        r = nextRand();
        flushPipeAndPc = (r[4:0] == 5'd0);
        vicCtrl        = (r[9:5] == 5'd0);
        ifIdFlush      = (r[14:10] == 5'd0);
        pcStall        = (r[17:15] == 3'd0);
        ifIdStall      = (r[20:18] == 3'd0);
        writeEnable    = (r[23:21] == 3'd0);
        jmpAddr   = randAddr();
        vicAddr   = randAddr();
        chJmpAddr = randAddr();

        r = nextRand();
        cbNew = fetchPkg::counterT'(r[1:0]);
        // Mostly near the fetch pc and sometimes same index with another tag
        case (r[3:2])
            2'd0, 2'd1: jmpInstrAddr = modelPc + {r[5:4], 2'b00};
            2'd2:       jmpInstrAddr = randAddr();
            default:    jmpInstrAddr = modelPc ^ 32'h0001_0000;
        endcase
    endtask

    // Four-phase memory acking after 0 to 3 cycles
    task automatic answerMemory();
        logic [31:0] r;
        if (imemAck) begin
            if (!imemReq) begin
                imemAck = 1'b0;
            end
        end else if (imemReq) begin
            if (!ackPending) begin
                r = nextRand();
                ackPending = 1'b1;
                ackDelay = int'(r[1:0]);
            end
            if (ackDelay == 0) begin
                imemAck = 1'b1;
                imemData = wordHash(imemAddr);
                ackPending = 1'b0;
            end else begin
                ackDelay--;
            end
        end else begin
            ackPending = 1'b0;
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        reset = 1'b1;
        flushPipeAndPc = 1'b0;
        pcStall = 1'b0;
        ifIdFlush = 1'b0;
        ifIdStall = 1'b0;
        writeEnable = 1'b0;
        vicCtrl = 1'b0;
        imemAck = 1'b0;
        cbNew = fetchPkg::strongNotTaken;
        jmpAddr = '0;
        chJmpAddr = '0;
        jmpInstrAddr = '0;
        vicAddr = '0;
        imemData = '0;

        modelPc = `FETCH_RESET_PC;
        for (int i = 0; i < tableSize; i++) begin
            modelTable[i] = '0;
        end
        expIr = `FETCH_NOP;
        expIrValid = 1'b0;
        expPcSource = 1'b0;
        expPcMatch = 1'b0;
        expInstrAddr = '0;
        expPredict = '0;
        expCb = fetchPkg::strongNotTaken;
        discarded = 1'b0;
        payloadKnown = 1'b0;
        lastHit = 1'b0;
        expectReqHeld = 1'b0;
        wasReset = 1'b0;
        timedOut = 1'b0;
        ackPending = 1'b0;
        ackDelay = 0;
        completions = 0;
        idleCycles = 0;
        // Held from time zero for five edges in all
        resetLeft = 4;
        nextResetAt = 500;

        while (completions < doneTarget && !timedOut) begin
            @(negedge Clk);
            stepModel();
            if (idleCycles > idleLimit) begin
                timedOut = 1'b1;
            end else begin
                @(posedge Clk);
                #1;
                compareOutputs();
                driveHazards();
                answerMemory();
            end
        end

        if (timedOut) begin
            $display("timeout: no fetch completed within %0d cycles", idleLimit);
            $display("FAIL: see errors above");
            $fatal(1, "fetch stage stopped completing");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

/* fetchLogic.f */
+incdir+hw
hw/imemPkg.sv
hw/fetchPkg.sv
hw/pcUpdate.sv
hw/predictCache.sv
hw/fetchLogic.sv
tb/fetchLogic_props.sv
tb/fetchLogicTb.sv
